// ==== vlog.f ====
hdl/fcpu_pkg.sv
hdl/fcpu_ctrl_pkg.sv
hdl/register_file.sv
hdl/issue_ctrl.sv
hdl/rob_ptr.sv
hdl/rob_store.sv
hdl/fcpu_rename_top.sv
test/tb_fcpu_rename.sv

// ==== Makefile ====
TOP := tb_fcpu_rename

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== test/tb_fcpu_rename.sv ====
`timescale 1ns/1ps

module tb_fcpu_rename;

   localparam int DEPTH = 8;
   localparam int DW = fcpu_pkg::DATA_W;
   localparam int AW = fcpu_pkg::REG_ADDR_W;
   localparam int IW = fcpu_pkg::RSV_ID_W;
   localparam int WATCHDOG_CYCLES = 400 + 200;   // Test lengths plus margin

   logic clk = 1'b0;
   logic nrst = 1'b1;
   logic issue_valid = 1'b0;
   logic [AW-1:0] src_a = '0;
   logic [AW-1:0] src_b = '0;
   logic [AW-1:0] dst = '0;
   logic res_we = 1'b0;
   logic [IW-1:0] res_id = '0;
   logic [DW-1:0] res_data = '0;
   logic branch_miss = 1'b0;
   logic [DW-1:0] op_data [2];
   logic [IW-1:0] op_tag [2];
   logic op_filled [2];
   logic [IW-1:0] issue_id;
   logic stall;

   // Reference model state
   logic [DW-1:0] m_regs [fcpu_pkg::N_REGS];
   logic [IW-1:0] m_tags [fcpu_pkg::N_REGS];
   logic m_filled [fcpu_pkg::N_REGS];
   logic [AW-1:0] ent_dst [DEPTH];
   logic [DW-1:0] ent_data [DEPTH];
   logic ent_done [DEPTH];
   int q [$];                                     // Outstanding ids with the oldest first
   int m_tail;
   fcpu_ctrl_pkg::issue_state_t m_state;
   logic [AW-1:0] watch_a = '0;
   logic [AW-1:0] watch_b = '0;

   fcpu_rename_top #(.ROB_DEPTH(DEPTH)) i_fcpu_rename_top (
      .clk(clk), .nrst(nrst), .issue_valid(issue_valid), .src_a(src_a), .src_b(src_b),
      .dst(dst), .res_we(res_we), .res_id(res_id), .res_data(res_data),
      .branch_miss(branch_miss), .op_data(op_data), .op_tag(op_tag),
      .op_filled(op_filled), .issue_id(issue_id), .stall(stall)
   );

   always #50 clk = ~clk;

   // ************************************************************************
   // Reference model that sees the same inputs as the DUT at each rising edge
   // ************************************************************************

   always @(posedge clk) begin : model
      logic commit;
      logic alloc;
      int hid;
      if (nrst) begin
         for (int i = 0; i < fcpu_pkg::N_REGS; i++) begin
            m_regs[i] = '0;
            m_tags[i] = '0;
            m_filled[i] = 1'b1;
         end
         for (int i = 0; i < DEPTH; i++) ent_done[i] = 1'b0;
         q.delete();
         m_tail = 0;
         m_state = fcpu_ctrl_pkg::RUN;
      end else begin
         commit = q.size() != 0 && m_state != fcpu_ctrl_pkg::FLUSH && ent_done[q[0]];
         alloc = issue_valid && m_state == fcpu_ctrl_pkg::RUN;
         hid = commit ? q[0] : 0;
         if (commit) m_regs[ent_dst[hid]] = ent_data[hid];   // Data always lands
         if (branch_miss) begin
            for (int i = 0; i < fcpu_pkg::N_REGS; i++) begin
               m_tags[i] = '0;
               m_filled[i] = 1'b1;
            end
            for (int i = 0; i < DEPTH; i++) ent_done[i] = 1'b0;
            q.delete();
            m_tail = 0;
            m_state = fcpu_ctrl_pkg::FLUSH;
         end else begin
            if (commit && m_tags[ent_dst[hid]] == IW'(hid)) begin
               m_tags[ent_dst[hid]] = '0;
               m_filled[ent_dst[hid]] = 1'b1;
            end
            if (alloc) begin
               m_tags[dst] = IW'(m_tail);   // Reservation overrides a release
               m_filled[dst] = 1'b0;
            end
            if (res_we) begin
               ent_data[res_id] = res_data;
               ent_done[res_id] = 1'b1;
            end
            if (commit) begin
               ent_done[hid] = 1'b0;
               void'(q.pop_front());
            end
            if (alloc) begin
               ent_dst[m_tail] = dst;
               ent_done[m_tail] = 1'b0;
               q.push_back(m_tail);
               m_tail = (m_tail + 1) % DEPTH;
            end
            m_state = (q.size() == DEPTH && m_state != fcpu_ctrl_pkg::FLUSH) ?
                      fcpu_ctrl_pkg::FULL : fcpu_ctrl_pkg::RUN;
         end
      end
   end

   task automatic fail_value(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] act);
      $display("[ERROR] %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic fail_text(input string what);
      $display("%0t ns: %s", $time, what);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_equal(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
      assert (act === exp) else fail_value(name, exp, act);
   endtask

   // Compares the watched registers, stall and issue_id with the model
   task automatic compare_outputs();
      check_equal("op_data[0]", m_regs[watch_a], op_data[0]);
      check_equal("op_data[1]", m_regs[watch_b], op_data[1]);
      check_equal("op_tag[0]", DW'(m_tags[watch_a]), DW'(op_tag[0]));
      check_equal("op_tag[1]", DW'(m_tags[watch_b]), DW'(op_tag[1]));
      check_equal("op_filled[0]", DW'(m_filled[watch_a]), DW'(op_filled[0]));
      check_equal("op_filled[1]", DW'(m_filled[watch_b]), DW'(op_filled[1]));
      check_equal("stall", DW'(m_state != fcpu_ctrl_pkg::RUN), DW'(stall));
      check_equal("issue_id", DW'(m_tail), DW'(issue_id));
   endtask

   // Drives one cycle on the rising edge and checks at the falling edge
   task automatic step(input logic iv, input logic [AW-1:0] d, input logic rw,
                       input logic [IW-1:0] rid, input logic [DW-1:0] rdata,
                       input logic bm);
      @(posedge clk);
      issue_valid <= iv;
      dst <= d;
      res_we <= rw;
      res_id <= rid;
      res_data <= rdata;
      branch_miss <= bm;
      src_a <= watch_a;
      src_b <= watch_b;
      @(negedge clk);
      compare_outputs();
   endtask

   task automatic idle();
      step(1'b0, '0, 1'b0, '0, '0, 1'b0);
   endtask

   task automatic issue_to(input logic [AW-1:0] d);
      step(1'b1, d, 1'b0, '0, '0, 1'b0);
   endtask

   task automatic send_result(input logic [IW-1:0] id, input logic [DW-1:0] data);
      step(1'b0, '0, 1'b1, id, data, 1'b0);
   endtask

   task automatic wait_filled(input logic [AW-1:0] r);
      int n;
      watch_a = r;
      n = 0;
      idle();
      while (!op_filled[0]) begin
         n++;
         if (n > 20) fail_text($sformatf("register %0d never became filled", r));
         idle();
      end
   endtask

   // Reads every register through both ports
   task automatic sweep_regs(input logic need_filled);
      for (int i = 0; i < fcpu_pkg::N_REGS; i++) begin
         watch_a = AW'(i);
         watch_b = AW'(fcpu_pkg::N_REGS - 1 - i);
         idle();
         if (need_filled) begin
            check_equal("op_filled[0]", 1, DW'(op_filled[0]));
            check_equal("op_filled[1]", 1, DW'(op_filled[1]));
         end
      end
   endtask

   task automatic reset_state_reads();
      sweep_regs(1'b1);
      check_equal("stall", 0, DW'(stall));
   endtask

   task automatic single_issue_retire();
      logic [AW-1:0] r;
      logic [IW-1:0] id;
      logic [DW-1:0] d;
      r = AW'($urandom);
      d = $urandom;
      watch_a = r;
      idle();
      issue_to(r);
      id = IW'(m_tail);
      idle();
      check_equal("op_tag[0]", DW'(id), DW'(op_tag[0]));
      check_equal("op_filled[0]", 0, DW'(op_filled[0]));
      send_result(id, d);
      wait_filled(r);
      check_equal("op_data[0]", d, op_data[0]);
   endtask

   task automatic reverse_order_results();
      logic [AW-1:0] r [4];
      logic [IW-1:0] id [4];
      logic [DW-1:0] d [4];
      int s;
      s = $urandom % fcpu_pkg::N_REGS;
      for (int i = 0; i < 4; i++) begin
         r[i] = AW'(s + i);
         d[i] = $urandom;
         issue_to(r[i]);
         id[i] = IW'(m_tail);
      end
      watch_a = r[0];
      watch_b = r[3];
      for (int i = 3; i > 0; i--) begin
         send_result(id[i], d[i]);
         idle();
         check_equal("op_filled[0]", 0, DW'(op_filled[0]));   // Older entry blocks
         check_equal("op_filled[1]", 0, DW'(op_filled[1]));
      end
      send_result(id[0], d[0]);
      wait_filled(r[3]);
      check_equal("op_data[0]", d[3], op_data[0]);
      sweep_regs(1'b1);
   endtask

   task automatic rereserve_register();
      logic [AW-1:0] r;
      logic [IW-1:0] id1;
      logic [IW-1:0] id2;
      logic [DW-1:0] d1;
      logic [DW-1:0] d2;
      r = AW'($urandom);
      d1 = $urandom;
      d2 = $urandom;
      watch_a = r;
      issue_to(r);
      id1 = IW'(m_tail);
      issue_to(r);
      id2 = IW'(m_tail);
      send_result(id1, d1);
      idle();
      idle();                                      // Commit edge of the first entry
      check_equal("op_data[0]", d1, op_data[0]);
      check_equal("op_filled[0]", 0, DW'(op_filled[0]));
      check_equal("op_tag[0]", DW'(id2), DW'(op_tag[0]));
      send_result(id2, d2);
      wait_filled(r);
      check_equal("op_data[0]", d2, op_data[0]);
   endtask

   task automatic fill_rob();
      logic [IW-1:0] first;
      logic [IW-1:0] tag_before;
      logic [IW-1:0] id_before;
      logic [AW-1:0] x;
      first = IW'(m_tail);
      for (int i = 0; i < DEPTH; i++) issue_to(AW'($urandom));
      x = AW'($urandom);
      watch_a = x;
      idle();
      check_equal("stall", 1, DW'(stall));
      tag_before = m_tags[x];
      id_before = IW'(m_tail);
      issue_to(x);
      idle();                                      // The ignored issue meets its edge
      check_equal("op_tag[0]", DW'(tag_before), DW'(op_tag[0]));
      check_equal("issue_id", DW'(id_before), DW'(issue_id));
      send_result(first, $urandom);
      idle();
      idle();
      check_equal("stall", 0, DW'(stall));
   endtask

   task automatic flush_on_branch_miss();
      logic [AW-1:0] r;
      step(1'b0, '0, 1'b0, '0, '0, 1'b1);
      idle();
      check_equal("stall", 1, DW'(stall));         // FLUSH cycle
      sweep_regs(1'b1);
      for (int i = 1; i < 4; i++) send_result(IW'(i), $urandom);
      sweep_regs(1'b1);
      r = AW'($urandom);
      watch_a = r;
      issue_to(r);
      check_equal("issue_id", 0, DW'(issue_id));
      idle();
      check_equal("op_tag[0]", 0, DW'(op_tag[0]));
      check_equal("op_filled[0]", 0, DW'(op_filled[0]));
   endtask

   initial begin
      #(100 * WATCHDOG_CYCLES);
      fail_text("watchdog expired before the tests completed");
   end

   initial begin
      void'($urandom(32'h46d1_7278));
      repeat (2) @(posedge clk);
      nrst <= 1'b0;
      @(negedge clk);
      reset_state_reads();
      single_issue_retire();
      reverse_order_results();
      rereserve_register();
      fill_rob();
      flush_on_branch_miss();
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== hdl/fcpu_rename_top.sv ====
`timescale 1ns/1ps

module fcpu_rename_top #(
   parameter int ROB_DEPTH = fcpu_ctrl_pkg::ROB_DEPTH_DEFAULT
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic                            issue_valid,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] src_a,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] src_b,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] dst,
   input  logic                            res_we,
   input  logic [fcpu_pkg::RSV_ID_W-1:0]   res_id,
   input  logic [fcpu_pkg::DATA_W-1:0]     res_data,
   input  logic                            branch_miss,
   output logic [fcpu_pkg::DATA_W-1:0]     op_data [2],
   output logic [fcpu_pkg::RSV_ID_W-1:0]   op_tag [2],
   output logic                            op_filled [2],
   output logic [fcpu_pkg::RSV_ID_W-1:0]   issue_id,
   output logic                            stall
);

   logic                            alloc;
   logic                            commit;
   logic                            flush;
   logic [fcpu_pkg::RSV_ID_W-1:0]   head;
   logic [fcpu_pkg::RSV_ID_W-1:0]   tail;
   logic [fcpu_pkg::RSV_ID_W:0]     count;
   logic                            head_done;
   logic [fcpu_pkg::REG_ADDR_W-1:0] head_dst;
   logic [fcpu_pkg::DATA_W-1:0]     head_data;
   logic [fcpu_pkg::REG_ADDR_W-1:0] rd_addrs [fcpu_pkg::N_RD_PORTS];
   logic [fcpu_pkg::DATA_W-1:0]     rd_data [fcpu_pkg::N_RD_PORTS];
   logic [fcpu_pkg::RSV_ID_W-1:0]   rd_tag [fcpu_pkg::N_RD_PORTS];
   logic                            rd_filled [fcpu_pkg::N_RD_PORTS];

   assign rd_addrs[0]              = src_a;
   assign rd_addrs[1]              = src_b;
   assign rd_addrs[fcpu_pkg::DST_PORT] = dst;

   // Source operands come from ports 0 and 1
   for (genvar p = 0; p < 2; p++) begin : g_op
      assign op_data[p]   = rd_data[p];
      assign op_tag[p]    = rd_tag[p];
      assign op_filled[p] = rd_filled[p];
   end

   assign issue_id = tail;       // The tail id names the instruction issued now

   issue_ctrl #(.ROB_DEPTH(ROB_DEPTH)) i_issue_ctrl (
      .clk         (clk),
      .nrst        (nrst),
      .issue_valid (issue_valid),
      .branch_miss (branch_miss),
      .head_done   (head_done),
      .count       (count),
      .alloc       (alloc),
      .commit      (commit),
      .flush       (flush),
      .stall       (stall)
   );

   rob_ptr #(.ROB_DEPTH(ROB_DEPTH)) i_rob_ptr (
      .clk    (clk),
      .nrst   (nrst),
      .alloc  (alloc),
      .commit (commit),
      .flush  (flush),
      .head   (head),
      .tail   (tail),
      .count  (count)
   );

   rob_store #(.ROB_DEPTH(ROB_DEPTH)) i_rob_store (
      .clk       (clk),
      .nrst      (nrst),
      .alloc     (alloc),
      .tail      (tail),
      .alloc_dst (dst),
      .res_we    (res_we),
      .res_id    (res_id),
      .res_data  (res_data),
      .commit    (commit),
      .head      (head),
      .flush     (flush),
      .head_done (head_done),
      .head_dst  (head_dst),
      .head_data (head_data)
   );

   register_file i_register_file (
      .clk         (clk),
      .nrst        (nrst),
      .branch_miss (flush),
      .rsv         (alloc),
      .rob_id      (tail),
      .we          (commit),
      .wr_addr     (head_dst),
      .wr_data     (head_data),
      .wr_id       (head),
      .rd_addrs    (rd_addrs),
      .rd_data     (rd_data),
      .rd_tag      (rd_tag),
      .rd_filled   (rd_filled)
   );

endmodule

// ==== hdl/rob_store.sv ====
`timescale 1ns/1ps

module rob_store #(
   parameter int ROB_DEPTH = fcpu_ctrl_pkg::ROB_DEPTH_DEFAULT
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic                            alloc,
   input  logic [fcpu_pkg::RSV_ID_W-1:0]   tail,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] alloc_dst,
   input  logic                            res_we,
   input  logic [fcpu_pkg::RSV_ID_W-1:0]   res_id,
   input  logic [fcpu_pkg::DATA_W-1:0]     res_data,
   input  logic                            commit,
   input  logic [fcpu_pkg::RSV_ID_W-1:0]   head,
   input  logic                            flush,
   output logic                            head_done,
   output logic [fcpu_pkg::REG_ADDR_W-1:0] head_dst,
   output logic [fcpu_pkg::DATA_W-1:0]     head_data
);

   logic [fcpu_pkg::REG_ADDR_W-1:0] dst_q [ROB_DEPTH];
   logic [fcpu_pkg::DATA_W-1:0]     data_q [ROB_DEPTH];
   logic [ROB_DEPTH-1:0]            done;

   // Head entry seen by the controller and the register file
   assign head_done = done[head];
   assign head_dst  = dst_q[head];
   assign head_data = data_q[head];

   // **************************************************************************
   // Entry payload
   // **************************************************************************

   always_ff @(posedge clk) begin
      if (alloc) begin
         dst_q[tail] <= alloc_dst;
      end
      if (res_we) begin
         data_q[res_id] <= res_data;   // Results arrive in any order
      end
   end

   // Done flags
   always_ff @(posedge clk) begin
      if (nrst || flush) begin
         done <= '0;
      end else begin
         if (res_we) begin
            done[res_id] <= 1'b1;
         end
         if (commit) begin
            done[head] <= 1'b0;
         end
         if (alloc) begin
            done[tail] <= 1'b0;          // A fresh entry waits for its result
         end
      end
   end

endmodule

// ==== hdl/rob_ptr.sv ====
`timescale 1ns/1ps

module rob_ptr #(
   parameter int ROB_DEPTH = fcpu_ctrl_pkg::ROB_DEPTH_DEFAULT
) (
   input  logic                          clk,
   input  logic                          nrst,
   input  logic                          alloc,
   input  logic                          commit,
   input  logic                          flush,
   output logic [fcpu_pkg::RSV_ID_W-1:0] head,
   output logic [fcpu_pkg::RSV_ID_W-1:0] tail,
   output logic [fcpu_pkg::RSV_ID_W:0]   count
);

   localparam int                          IW       = fcpu_pkg::RSV_ID_W;
   localparam logic [fcpu_pkg::RSV_ID_W-1:0] LAST_ID = IW'(ROB_DEPTH - 1);

   // Pointer step modulo ROB_DEPTH
   function automatic logic [fcpu_pkg::RSV_ID_W-1:0] ptr_inc(
      input logic [fcpu_pkg::RSV_ID_W-1:0] ptr
   );
      if (ptr == LAST_ID) begin
         return '0;
      end
      return ptr + IW'(1);
   endfunction

   always_ff @(posedge clk) begin
      if (nrst || flush) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (alloc) begin
            tail <= ptr_inc(tail);
         end
         if (commit) begin
            head <= ptr_inc(head);
         end
         if (alloc && !commit) begin
            count <= count + (IW + 1)'(1);
         end else if (commit && !alloc) begin
            count <= count - (IW + 1)'(1);
         end
      end
   end

endmodule

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl #(
   parameter int ROB_DEPTH = fcpu_ctrl_pkg::ROB_DEPTH_DEFAULT
) (
   input  logic                        clk,
   input  logic                        nrst,
   input  logic                        issue_valid,
   input  logic                        branch_miss,
   input  logic                        head_done,
   input  logic [fcpu_pkg::RSV_ID_W:0] count,
   output logic                        alloc,
   output logic                        commit,
   output logic                        flush,
   output logic                        stall
);

   localparam int            CW         = fcpu_pkg::RSV_ID_W + 1;
   localparam logic [CW-1:0] FULL_COUNT = CW'(ROB_DEPTH);

   fcpu_ctrl_pkg::issue_state_t state;
   fcpu_ctrl_pkg::issue_state_t state_nxt;
   logic [CW-1:0]               count_nxt;

   assign alloc  = issue_valid && (state == fcpu_ctrl_pkg::RUN);
   assign commit = head_done && (count != '0) && (state != fcpu_ctrl_pkg::FLUSH);
   assign flush  = branch_miss;
   assign stall  = (state != fcpu_ctrl_pkg::RUN);

   // Occupancy after this edge, alloc and commit together cancel
   always_comb begin
      count_nxt = count;
      if (alloc && !commit) begin
         count_nxt = count + CW'(1);
      end else if (commit && !alloc) begin
         count_nxt = count - CW'(1);
      end
   end

   always_comb begin
      state_nxt = fcpu_ctrl_pkg::RUN;
      if (branch_miss) begin
         state_nxt = fcpu_ctrl_pkg::FLUSH;
      end else if (state != fcpu_ctrl_pkg::FLUSH && count_nxt == FULL_COUNT) begin
         state_nxt = fcpu_ctrl_pkg::FULL;
      end
      // FLUSH always lasts a single cycle
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state <= fcpu_ctrl_pkg::RUN;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
   input  logic                                clk,
   input  logic                                nrst,
   input  logic                                branch_miss,
   input  logic                                rsv,      // Reserve the port 2 register
   input  logic [fcpu_pkg::RSV_ID_W-1:0]       rob_id,
   input  logic                                we,       // Commit from the ROB head
   input  logic [fcpu_pkg::REG_ADDR_W-1:0]     wr_addr,
   input  logic [fcpu_pkg::DATA_W-1:0]         wr_data,
   input  logic [fcpu_pkg::RSV_ID_W-1:0]       wr_id,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0]     rd_addrs [fcpu_pkg::N_RD_PORTS],
   output logic [fcpu_pkg::DATA_W-1:0]         rd_data [fcpu_pkg::N_RD_PORTS],
   output logic [fcpu_pkg::RSV_ID_W-1:0]       rd_tag [fcpu_pkg::N_RD_PORTS],
   output logic                                rd_filled [fcpu_pkg::N_RD_PORTS]
);

   localparam int N_REGS = fcpu_pkg::N_REGS;
   localparam int AW     = fcpu_pkg::REG_ADDR_W;

   logic [N_REGS-1:0][fcpu_pkg::DATA_W-1:0]   regs;
   logic [N_REGS-1:0][fcpu_pkg::RSV_ID_W-1:0] tags;
   logic [N_REGS-1:0]                         filled;
   logic [N_REGS-1:0]                         rsv_hit;
   logic [N_REGS-1:0]                         release_hit;

   // Combinational read ports, the values are those before the next edge
   for (genvar p = 0; p < fcpu_pkg::N_RD_PORTS; p++) begin : g_rd
      assign rd_data[p]   = regs[rd_addrs[p]];
      assign rd_tag[p]    = tags[rd_addrs[p]];
      assign rd_filled[p] = filled[rd_addrs[p]];
   end

   // A commit releases the tag only if it still belongs to the committing entry
   always_comb begin
      for (int i = 0; i < N_REGS; i++) begin
         rsv_hit[i]     = rsv && (rd_addrs[fcpu_pkg::DST_PORT] == AW'(i));
         release_hit[i] = we && (wr_addr == AW'(i)) && (tags[i] == wr_id);
      end
   end

   // **************************************************************************
   // Tags and filled flags
   // **************************************************************************

   always_ff @(posedge clk) begin
      if (nrst) begin
         tags   <= '0;
         filled <= '1;
      end else if (branch_miss) begin
         tags   <= '0;                  // Data stays, every result is committed
         filled <= '1;
      end else begin
         for (int i = 0; i < N_REGS; i++) begin
            if (rsv_hit[i]) begin
               tags[i]   <= rob_id;     // Reservation wins over a commit
               filled[i] <= 1'b0;
            end else if (release_hit[i]) begin
               tags[i]   <= '0;
               filled[i] <= 1'b1;
            end
         end
      end
   end

   // Data is written on every commit, matched or not
   always_ff @(posedge clk) begin
      if (nrst) begin
         regs <= '0;
      end else if (we) begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

// ==== hdl/fcpu_ctrl_pkg.sv ====
package fcpu_ctrl_pkg;

   // **************************************************************************
   // Issue controller
   // **************************************************************************

   // RUN accepts issues, FULL waits for a retirement, FLUSH lasts one cycle
   typedef enum logic [1:0] {
      RUN   = 2'd0,
      FULL  = 2'd1,
      FLUSH = 2'd2
   } issue_state_t;

   // Reorder buffer depth unless the top level overrides it
   localparam int ROB_DEPTH_DEFAULT = 8;

endpackage

// ==== hdl/fcpu_pkg.sv ====
package fcpu_pkg;

   // **************************************************************************
   // Datapath widths
   // **************************************************************************

   // Register and result width
   localparam int DATA_W = 32;

   // Architectural register address, 16 registers
   localparam int REG_ADDR_W = 4;
   localparam int N_REGS     = 2 ** REG_ADDR_W;

   // ROB id width, every ROB depth must fit within it
   localparam int RSV_ID_W = 3;

   // Read ports of the register file
   // Ports 0 and 1 are the sources, port 2 is the destination
   localparam int N_RD_PORTS = 3;
   localparam int DST_PORT   = 2;

endpackage
